//--- Bender.yml
package:
  name: tcp_rx_demux

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tcp_rx_pkg.sv
      - hdl/stream_fifo.sv
      - hdl/rx_meta_router.sv
      - hdl/rx_data_steer.sv
      - hdl/tcp_rx_demux.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/tb_tcp_rx_demux.sv

//--- all.f
+incdir+hdl
hdl/tcp_rx_pkg.sv
hdl/stream_fifo.sv
hdl/rx_meta_router.sv
hdl/rx_data_steer.sv
hdl/tcp_rx_demux.sv
bench/tb_tcp_rx_demux.sv

//--- bench/tb_tcp_rx_demux.sv
`include "tcp_rx_settings.svh"

module tb_tcp_rx_demux;

  timeunit 1ns;
  timeprecision 1ps;

  import tcp_rx_pkg::*;

  // Under 100 beats in all tests plus a wide margin
  localparam int max_cycles = 2000;

  logic                                          aclk;
  logic                                          aresetn;
  logic                                          meta_valid;
  logic                                          meta_ready;
  rx_meta_t                                      meta;
  logic                                          data_valid;
  logic                                          data_ready;
  beat_t                                         data_beat;
  logic [`TCP_N_REGIONS-1:0]                     rmeta_valid;
  logic [`TCP_N_REGIONS-1:0]                     rmeta_ready;
  region_meta_t [`TCP_N_REGIONS-1:0]             rmeta;
  logic [`TCP_N_REGIONS-1:0]                     rdata_valid;
  logic [`TCP_N_REGIONS-1:0]                     rdata_ready;
  beat_t [`TCP_N_REGIONS-1:0]                    rdata;
  logic [`TCP_N_REGIONS-1:0]                     region_fill_ok;

  // Scoreboard queues per region and stream
  region_meta_t exp_meta [`TCP_N_REGIONS][$];
  beat_t        exp_beat [`TCP_N_REGIONS][$];
  int           cycles;

  tcp_rx_demux u_dut (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .meta_valid     (meta_valid),
    .meta_ready     (meta_ready),
    .meta           (meta),
    .data_valid     (data_valid),
    .data_ready     (data_ready),
    .data_beat      (data_beat),
    .rmeta_valid    (rmeta_valid),
    .rmeta_ready    (rmeta_ready),
    .rmeta          (rmeta),
    .rdata_valid    (rdata_valid),
    .rdata_ready    (rdata_ready),
    .rdata          (rdata),
    .region_fill_ok (region_fill_ok)
  );

  // 4 ns clock
  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                          name, actual, expected));
    end
  endtask

  // Hang guard
  always @(posedge aclk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      abort_run($sformatf("Timeout: tests still running after %0d cycles", cycles));
    end
  end

  // --------------------------------------------------
  // Output monitor
  // --------------------------------------------------
  // Handshakes sampled at the edge where they complete
  always @(posedge aclk) begin
    region_meta_t m;
    beat_t        b;
    if (aresetn) begin
      for (int i = 0; i < `TCP_N_REGIONS; i++) begin
        if (rmeta_valid[i] && rmeta_ready[i]) begin
          if (exp_meta[i].size() == 0) begin
            abort_run($sformatf("Metadata came out on region %0d with none expected", i));
          end else begin
            m = exp_meta[i].pop_front();
            check_value($sformatf("rmeta[%0d]", i), rmeta[i], m);
          end
        end
        if (rdata_valid[i] && rdata_ready[i]) begin
          if (exp_beat[i].size() == 0) begin
            abort_run($sformatf("A data beat came out on region %0d with none expected", i));
          end else begin
            b = exp_beat[i].pop_front();
            check_value($sformatf("rdata[%0d]", i), rdata[i], b);
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Stimulus helpers called and returning at negedge
  // --------------------------------------------------
  task automatic present_meta(input int region, input int len, output region_meta_t rm);
    rx_meta_t m;
    m.region = `TCP_REGION_BITS'(region);
    m.len    = `TCP_LEN_BITS'(len);
    m.pid    = 6'($urandom);
    m.dest   = 12'($urandom);
    // Region sees the word minus its id
    rm.len   = m.len;
    rm.pid   = m.pid;
    rm.dest  = m.dest;
    exp_meta[region].push_back(rm);
    meta       = m;
    meta_valid = 1'b1;
  endtask

  task automatic wait_meta_accept();
    do begin
      @(posedge aclk);
    end while (!meta_ready);
    @(negedge aclk);
  endtask

  task automatic send_meta(input int region, input int len, output region_meta_t rm);
    present_meta(region, len, rm);
    wait_meta_accept();
  endtask

  // Random beat whose expected copy carries the model's last
  task automatic queue_beat(input int region, input bit last, output beat_t b);
    b.data = {$urandom, $urandom};
    b.keep = 8'($urandom);
    b.last = last;
    exp_beat[region].push_back(b);
  endtask

  task automatic wait_beat_accept();
    do begin
      @(posedge aclk);
    end while (!data_ready);
    @(negedge aclk);
  endtask

  // Beats are the length over 8 rounded up
  task automatic send_payload(input int region, input int len, input bit bad_last);
    int    n;
    beat_t b;
    n = (len + 7) / 8;
    for (int i = 0; i < n; i++) begin
      queue_beat(region, i == n - 1, b);
      // Wrong last on the wire must not leak through
      if (bad_last) begin
        b.last = ~b.last;
      end
      data_beat  = b;
      data_valid = 1'b1;
      wait_beat_accept();
    end
    data_valid = 1'b0;
  endtask

  function automatic int pending_items();
    int total;
    total = 0;
    for (int i = 0; i < `TCP_N_REGIONS; i++) begin
      total += exp_meta[i].size() + exp_beat[i].size();
    end
    return total;
  endfunction

  task automatic wait_drained();
    while (pending_items() != 0) begin
      @(negedge aclk);
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset();
    repeat (5) @(negedge aclk);
    check_value("meta_ready", meta_ready, 1'b0);
    check_value("data_ready", data_ready, 1'b0);
    check_value("rmeta_valid", rmeta_valid, '0);
    check_value("rdata_valid", rdata_valid, '0);
    check_value("region_fill_ok", region_fill_ok, 4'hf);
    aresetn = 1'b1;
    @(negedge aclk);
    check_value("meta_ready", meta_ready, 1'b1);
    check_value("data_ready", data_ready, 1'b0);
  endtask

  task automatic test_single_packet();
    region_meta_t rm;
    send_meta(2, 64, rm);
    meta_valid = 1'b0;
    // Only region 2 valid one cycle after acceptance
    check_value("rmeta_valid", rmeta_valid, 4'b0100);
    check_value("rmeta[2]", rmeta[2], rm);
    send_payload(2, 64, 1'b0);
    wait_drained();
  endtask

  task automatic test_beat_counts();
    region_meta_t rm;
    send_meta(0, 1, rm);
    send_meta(1, 9, rm);
    send_meta(3, 17, rm);
    meta_valid = 1'b0;
    send_payload(0, 1, 1'b1);
    send_payload(1, 9, 1'b1);
    send_payload(3, 17, 1'b1);
    wait_drained();
  endtask

  task automatic test_mixed_regions();
    int           regions [6] = '{1, 3, 1, 0, 3, 2};
    int           lens [6]    = '{24, 8, 40, 16, 33, 7};
    region_meta_t rm;
    // All metadata first and payloads in the same order
    for (int i = 0; i < 6; i++) begin
      send_meta(regions[i], lens[i], rm);
    end
    meta_valid = 1'b0;
    for (int i = 0; i < 6; i++) begin
      send_payload(regions[i], lens[i], 1'b0);
    end
    wait_drained();
  endtask

  task automatic test_backpressure();
    region_meta_t rm;
    beat_t        b;
    rmeta_ready[1] = 1'b0;
    rdata_ready[1] = 1'b0;
    // Fill region 1's metadata queue
    send_meta(1, 256, rm);
    repeat (3) send_meta(1, 8, rm);
    present_meta(1, 8, rm);
    repeat (3) begin
      @(negedge aclk);
      check_value("meta_ready", meta_ready, 1'b0);
    end
    // 32 beats fill the buffer so the next one stalls
    send_payload(1, 256, 1'b0);
    queue_beat(1, 1'b1, b);
    data_beat  = b;
    data_valid = 1'b1;
    repeat (3) begin
      @(negedge aclk);
      check_value("data_ready", data_ready, 1'b0);
    end
    // Buffer stays full until the metadata side is done
    rmeta_ready[1] = 1'b1;
    wait_meta_accept();
    meta_valid     = 1'b0;
    rdata_ready[1] = 1'b1;
    wait_beat_accept();
    data_valid = 1'b0;
    repeat (3) send_payload(1, 8, 1'b0);
    wait_drained();
  endtask

  task automatic test_fill_flag();
    region_meta_t rm;
    beat_t        b;
    rdata_ready[3] = 1'b0;
    send_meta(3, 136, rm);
    meta_valid = 1'b0;
    for (int i = 0; i < 17; i++) begin
      queue_beat(3, i == 16, b);
      data_beat  = b;
      data_valid = 1'b1;
      wait_beat_accept();
      // High up to 16 held beats
      check_value("region_fill_ok[3]", region_fill_ok[3], i < 16);
    end
    data_valid     = 1'b0;
    rdata_ready[3] = 1'b1;
    // One pop brings it back to 16
    @(negedge aclk);
    check_value("region_fill_ok[3]", region_fill_ok[3], 1'b1);
    wait_drained();
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(39286));
    cycles      = 0;
    aresetn     = 1'b0;
    meta_valid  = 1'b0;
    meta        = '0;
    data_valid  = 1'b0;
    data_beat   = '0;
    rmeta_ready = '1;
    rdata_ready = '1;

    test_reset();
    test_single_packet();
    test_beat_counts();
    test_mixed_regions();
    test_backpressure();
    test_fill_flag();

    $display("No errors");
    $finish;
  end

endmodule

//--- hdl/rx_data_steer.sv
`include "tcp_rx_settings.svh"

module rx_data_steer (
  input  logic                                      aclk,
  input  logic                                      aresetn,
  input  logic                                      seq_valid,
  output logic                                      seq_ready,
  input  tcp_rx_pkg::seq_entry_t                    seq_entry,
  input  logic                                      data_valid,
  output logic                                      data_ready,
  input  tcp_rx_pkg::beat_t                         data_beat,
  output logic [`TCP_N_REGIONS-1:0]                 rdata_valid,
  input  logic [`TCP_N_REGIONS-1:0]                 rdata_ready,
  output tcp_rx_pkg::beat_t [`TCP_N_REGIONS-1:0]    rdata,
  output logic [`TCP_N_REGIONS-1:0]                 region_fill_ok
);

  import tcp_rx_pkg::*;

  localparam int cnt_bits  = `TCP_LEN_BITS - `TCP_BEAT_BYTES_LOG;
  localparam int fill_bits = $clog2(`TCP_DATA_DEPTH) + 1;

  typedef enum logic {
    st_idle,
    st_xfer
  } state_t;

  state_t                                    state;
  state_t                                    state_next;
  logic [`TCP_REGION_BITS-1:0]               sel;
  logic [`TCP_REGION_BITS-1:0]               sel_next;
  logic [cnt_bits-1:0]                       cnt;
  logic [cnt_bits-1:0]                       cnt_next;
  logic [`TCP_LEN_BITS-1:0]                  len_m1;
  logic                                      beat_xfer;
  logic                                      tr_done;
  logic                                      take_entry;
  logic [`TCP_N_REGIONS-1:0]                 buf_valid;
  logic [`TCP_N_REGIONS-1:0]                 buf_ready;
  beat_t                                     buf_data;
  logic [`TCP_N_REGIONS-1:0][fill_bits-1:0]  buf_fill;

  // --------------------------------------------------
  // Handshakes and countdown helpers
  // --------------------------------------------------
  // Beats minus one, length is never zero
  assign len_m1     = seq_entry.len - 1'b1;
  assign data_ready = (state == st_xfer) && buf_ready[sel];
  assign beat_xfer  = data_valid & data_ready;
  assign tr_done    = beat_xfer && (cnt == '0);
  // New entry when idle or on the final beat, so packets chain
  assign seq_ready  = (state == st_idle) || tr_done;
  assign take_entry = seq_valid & seq_ready;

  // --------------------------------------------------
  // Next state and datapath
  // --------------------------------------------------
  always_comb begin
    state_next = state;
    sel_next   = sel;
    cnt_next   = cnt;
    if (take_entry) begin
      state_next = st_xfer;
      sel_next   = seq_entry.region;
      cnt_next   = len_m1[`TCP_LEN_BITS-1:`TCP_BEAT_BYTES_LOG];
    end else if (tr_done) begin
      // Nothing queued, wait for next entry
      state_next = st_idle;
    end else if (beat_xfer) begin
      cnt_next = cnt - 1'b1;
    end
  end

  // State under reset, region and count only valid in transfer
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
    sel <= sel_next;
    cnt <= cnt_next;
  end

  // Incoming last is ignored, regenerated from the count
  always_comb begin
    buf_data.data = data_beat.data;
    buf_data.keep = data_beat.keep;
    buf_data.last = (cnt == '0);
  end

  // --------------------------------------------------
  // Per-region data buffers
  // --------------------------------------------------
  for (genvar i = 0; i < `TCP_N_REGIONS; i++) begin : g_region
    // Only the selected buffer sees valid
    assign buf_valid[i] = (state == st_xfer) && (sel == `TCP_REGION_BITS'(i)) && data_valid;

    stream_fifo #(
      .T     (beat_t),
      .DEPTH (`TCP_DATA_DEPTH)
    ) u_data_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (buf_valid[i]),
      .in_ready  (buf_ready[i]),
      .in_data   (buf_data),
      .out_valid (rdata_valid[i]),
      .out_ready (rdata_ready[i]),
      .out_data  (rdata[i]),
      .fill      (buf_fill[i])
    );

    // High while the buffer holds at most the threshold
    assign region_fill_ok[i] = (buf_fill[i] <= fill_bits'(`TCP_FILL_THRS));
  end

endmodule

//--- hdl/rx_meta_router.sv
`include "tcp_rx_settings.svh"

module rx_meta_router (
  input  logic                                             aclk,
  input  logic                                             aresetn,
  input  logic                                             meta_valid,
  output logic                                             meta_ready,
  input  tcp_rx_pkg::rx_meta_t                             meta,
  output logic [`TCP_N_REGIONS-1:0]                        rmeta_valid,
  input  logic [`TCP_N_REGIONS-1:0]                        rmeta_ready,
  output tcp_rx_pkg::region_meta_t [`TCP_N_REGIONS-1:0]    rmeta,
  output logic                                             seq_valid,
  input  logic                                             seq_ready,
  output tcp_rx_pkg::seq_entry_t                           seq_entry
);

  import tcp_rx_pkg::*;

  logic [`TCP_N_REGIONS-1:0] rq_valid;
  logic [`TCP_N_REGIONS-1:0] rq_ready;
  region_meta_t              rq_data;
  seq_entry_t                seq_data;
  logic                      seq_in_ready;
  logic                      accept;

  // --------------------------------------------------
  // Input qualification
  // --------------------------------------------------
  // Need room in the sequence queue and in the addressed region queue
  assign meta_ready = seq_in_ready & rq_ready[meta.region];
  assign accept     = meta_valid & meta_ready;

  // Strip region id for the region side
  always_comb begin
    rq_data.len  = meta.len;
    rq_data.pid  = meta.pid;
    rq_data.dest = meta.dest;
  end

  // Sequence entry carries only routing info for stage 2
  always_comb begin
    seq_data.region = meta.region;
    seq_data.len    = meta.len;
  end

  // --------------------------------------------------
  // Per-region metadata queues
  // --------------------------------------------------
  for (genvar i = 0; i < `TCP_N_REGIONS; i++) begin : g_region
    // Region decode, only the addressed queue gets a write
    assign rq_valid[i] = accept && (meta.region == `TCP_REGION_BITS'(i));

    stream_fifo #(
      .T     (region_meta_t),
      .DEPTH (`TCP_META_DEPTH)
    ) u_meta_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (rq_valid[i]),
      .in_ready  (rq_ready[i]),
      .in_data   (rq_data),
      .out_valid (rmeta_valid[i]),
      .out_ready (rmeta_ready[i]),
      .out_data  (rmeta[i]),
      .fill      ()
    );
  end

  // --------------------------------------------------
  // Sequence queue, written together with region queue
  // --------------------------------------------------
  stream_fifo #(
    .T     (seq_entry_t),
    .DEPTH (`TCP_SEQ_DEPTH)
  ) u_seq_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (accept),
    .in_ready  (seq_in_ready),
    .in_data   (seq_data),
    .out_valid (seq_valid),
    .out_ready (seq_ready),
    .out_data  (seq_entry),
    .fill      ()
  );

endmodule

//--- hdl/stream_fifo.sv
module stream_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  T                       in_data,
  output logic                   out_valid,
  input  logic                   out_ready,
  output T                       out_data,
  output logic [$clog2(DEPTH):0] fill
);

  localparam int addr_bits = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_bits  = $clog2(DEPTH) + 1;

  // Storage, no reset needed on payload
  T                     mem [DEPTH];
  logic [addr_bits-1:0] wr_ptr;
  logic [addr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0]  count;
  logic [cnt_bits-1:0]  count_next;
  logic                 push;
  logic                 pop;

  // --------------------------------------------------
  // Handshakes
  // --------------------------------------------------
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;
  // Head entry sits in a register, visible one cycle after write
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign fill      = count;

  // Occupancy after this cycle
  always_comb begin
    case ({push, pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  // --------------------------------------------------
  // Pointers, count and registered not-full
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      // Held low through reset, rises on first cycle after
      in_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == addr_bits'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == addr_bits'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count_next;
      in_ready <= (count_next != cnt_bits'(DEPTH));
    end
  end

  // Write port
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

//--- hdl/tcp_rx_demux.sv
`include "tcp_rx_settings.svh"

module tcp_rx_demux (
  input  logic                                          aclk,
  input  logic                                          aresetn,
  // Metadata from the network stack
  input  logic                                          meta_valid,
  output logic                                          meta_ready,
  input  tcp_rx_pkg::rx_meta_t                          meta,
  // Payload from the network stack
  input  logic                                          data_valid,
  output logic                                          data_ready,
  input  tcp_rx_pkg::beat_t                             data_beat,
  // Per-region metadata
  output logic [`TCP_N_REGIONS-1:0]                     rmeta_valid,
  input  logic [`TCP_N_REGIONS-1:0]                     rmeta_ready,
  output tcp_rx_pkg::region_meta_t [`TCP_N_REGIONS-1:0] rmeta,
  // Per-region payload
  output logic [`TCP_N_REGIONS-1:0]                     rdata_valid,
  input  logic [`TCP_N_REGIONS-1:0]                     rdata_ready,
  output tcp_rx_pkg::beat_t [`TCP_N_REGIONS-1:0]        rdata,
  output logic [`TCP_N_REGIONS-1:0]                     region_fill_ok
);

  import tcp_rx_pkg::*;

  // --------------------------------------------------
  // Sequence link between the two stages
  // --------------------------------------------------
  logic       seq_valid;
  logic       seq_ready;
  seq_entry_t seq_entry;

  // Stage 1, metadata routing and packet log
  rx_meta_router u_meta_router (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .meta_valid  (meta_valid),
    .meta_ready  (meta_ready),
    .meta        (meta),
    .rmeta_valid (rmeta_valid),
    .rmeta_ready (rmeta_ready),
    .rmeta       (rmeta),
    .seq_valid   (seq_valid),
    .seq_ready   (seq_ready),
    .seq_entry   (seq_entry)
  );

  // Stage 2, payload steering and tlast generation
  rx_data_steer u_data_steer (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .seq_valid      (seq_valid),
    .seq_ready      (seq_ready),
    .seq_entry      (seq_entry),
    .data_valid     (data_valid),
    .data_ready     (data_ready),
    .data_beat      (data_beat),
    .rdata_valid    (rdata_valid),
    .rdata_ready    (rdata_ready),
    .rdata          (rdata),
    .region_fill_ok (region_fill_ok)
  );

endmodule

//--- hdl/tcp_rx_pkg.sv
`include "tcp_rx_settings.svh"

package tcp_rx_pkg;

  // --------------------------------------------------
  // Metadata from the network stack
  // --------------------------------------------------

  // One word per packet, region id on top
  typedef struct packed {
    logic [`TCP_REGION_BITS-1:0] region;
    logic [`TCP_LEN_BITS-1:0]    len;
    logic [5:0]                  pid;
    logic [11:0]                 dest;
  } rx_meta_t;

  // Metadata as seen by a region, id stripped
  typedef struct packed {
    logic [`TCP_LEN_BITS-1:0] len;
    logic [5:0]               pid;
    logic [11:0]              dest;
  } region_meta_t;

  // --------------------------------------------------
  // Sequence queue and payload
  // --------------------------------------------------

  // Where the next payload goes and how long it is
  typedef struct packed {
    logic [`TCP_REGION_BITS-1:0] region;
    logic [`TCP_LEN_BITS-1:0]    len;
  } seq_entry_t;

  // One payload beat, byte keep per lane
  typedef struct packed {
    logic [`TCP_DATA_BITS-1:0]   data;
    logic [`TCP_DATA_BITS/8-1:0] keep;
    logic                        last;
  } beat_t;

endpackage

//--- hdl/tcp_rx_settings.svh
`ifndef TCP_RX_SETTINGS_SVH
`define TCP_RX_SETTINGS_SVH

// --------------------------------------------------
// Region layout
// --------------------------------------------------
`define TCP_N_REGIONS      4
`define TCP_REGION_BITS    2

// --------------------------------------------------
// Packet and beat widths
// --------------------------------------------------
`define TCP_LEN_BITS       16
`define TCP_DATA_BITS      64
// 8 bytes per beat
`define TCP_BEAT_BYTES_LOG 3

// --------------------------------------------------
// Queue depths and buffer threshold
// --------------------------------------------------
`define TCP_META_DEPTH     4
// Packets announced but not yet steered
`define TCP_SEQ_DEPTH      8
`define TCP_DATA_DEPTH     32
`define TCP_FILL_THRS      16

`endif
